//--- compile.f
rtl/axi_bridge_pkg.sv
rtl/l2_req_fifo.sv
rtl/axi_bridge_ctrl.sv
rtl/axi_write_align.sv
rtl/axi_resp_collect.sv
rtl/l2_axi_bridge.sv
tests/l2_axi_bridge_sva.sv
tests/tb_l2_axi_bridge.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_l2_axi_bridge
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q 'PASSED' $(LOG); then \
		echo "simulation ended without a verdict"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_l2_axi_bridge.sv
module tb_l2_axi_bridge;
   timeunit 1ns;
   timeprecision 100ps;
   import axi_bridge_pkg::*;

   localparam int FIFO_DEPTH = 4;
   localparam int TIMEOUT    = 200;
   localparam int N_ROWS     = 14;

   typedef struct {
      l2_cmd_t    cmd;
      paddr_t     addr;
      tag_t       tag;
      line_data_t data;
      line_strb_t byte_en;
      line_data_t exp_data;
      logic       exp_err;
   } test_row_t;

   typedef struct {
      tag_t       id;
      line_data_t data;
      axi_resp_t  resp;
      int         due;
   } r_beat_t;

   logic       i_clk;
   logic       i_reset_n;
   logic       i_l2_req_valid;
   l2_req_t    i_l2_req;
   logic       o_l2_req_ready;
   logic       o_axi_ar_valid;
   logic       i_axi_ar_ready;
   paddr_t     o_axi_ar_addr;
   tag_t       o_axi_ar_id;
   logic       o_axi_aw_valid;
   logic       i_axi_aw_ready;
   axi_aw_t    o_axi_aw;
   logic       o_axi_w_valid;
   logic       i_axi_w_ready;
   axi_w_t     o_axi_w;
   logic       i_axi_b_valid;
   tag_t       i_axi_b_id;
   axi_resp_t  i_axi_b_resp;
   logic       i_axi_r_valid;
   tag_t       i_axi_r_id;
   line_data_t i_axi_r_data;
   axi_resp_t  i_axi_r_resp;
   logic       o_l2_resp_valid;
   l2_resp_t   o_l2_resp;
   logic       o_wr_ack_valid;
   tag_t       o_wr_ack_tag;
   logic       o_bus_error;

   test_row_t   table_rows [N_ROWS];
   line_data_t  ref_mem [16];
   line_data_t  slave_mem [16];
   paddr_t      exp_ar_addr_q [$];
   tag_t        exp_ar_id_q [$];
   l2_resp_t    exp_resp_q [$];
   tag_t        exp_ack_q [$];
   axi_aw_t     exp_aw_q [$];
   axi_w_t      exp_w_q [$];
   int unsigned lcg_state = 28;
   logic        hold_ready = 1'b0;
   logic        ref_err = 1'b0;
   int          n_rows = 0;

   l2_axi_bridge #(.FIFO_DEPTH(FIFO_DEPTH)) u_l2_axi_bridge (.*);

   initial begin
      i_clk = 1'b0;
      forever #10 i_clk = ~i_clk;
   end

   // ------------------------------
   // helpers and checks
   // ------------------------------
   function automatic logic [15:0] next_rand();
      lcg_state = lcg_state * 1103515245 + 12345;
      return lcg_state[30:15];
   endfunction

   function automatic line_data_t fill_line(int line);
      line_data_t d;
      for (int j = 0; j < 16; j++) d[8*j +: 8] = 8'(line * 16 + j) ^ 8'h5a;
      return d;
   endfunction

   // byte lane j of the request lands in lane j + offset
   function automatic axi_w_t expect_w(paddr_t addr, line_data_t data, line_strb_t be);
      axi_w_t w;
      int ofs;
      w = '0;
      ofs = int'(addr[3:0]);
      for (int j = 0; j + ofs < 16; j++) begin
         w.data[8*(j+ofs) +: 8] = data[8*j +: 8];
         w.strb[j+ofs] = be[j];
      end
      return w;
   endfunction

   function automatic l2_req_t row_req(int idx);
      test_row_t r;
      r = table_rows[idx];
      return '{cmd: r.cmd, addr: r.addr, tag: r.tag, data: r.data, byte_en: r.byte_en};
   endfunction

   function automatic int pending_count();
      return exp_ar_addr_q.size() + exp_resp_q.size() + exp_ack_q.size()
             + exp_aw_q.size() + exp_w_q.size();
   endfunction

   task automatic report_fail(string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_resp(string name, l2_resp_t exp, l2_resp_t act);
      if (act !== exp) report_fail($sformatf("FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_aw(string name, axi_aw_t exp, axi_aw_t act);
      if (act !== exp) report_fail($sformatf("FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_w(string name, axi_w_t exp, axi_w_t act);
      if (act !== exp) report_fail($sformatf("FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_addr(string name, paddr_t exp, paddr_t act);
      if (act !== exp) report_fail($sformatf("FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_tag(string name, tag_t exp, tag_t act);
      if (act !== exp) report_fail($sformatf("FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      if (act !== exp) report_fail($sformatf("FAILED %s expected %b actual %b", name, exp, act));
   endtask

   // expected values follow the reference memory in table order
   task automatic add_row(l2_cmd_t cmd, paddr_t addr, tag_t tag, line_strb_t be);
      test_row_t r;
      axi_w_t w;
      int line;
      line = int'(addr[7:4]);
      r.cmd = cmd;
      r.addr = addr;
      r.tag = tag;
      r.data = {4{32'hc0de_0000 | 32'(tag) << 8 | 32'(tag)}};
      r.byte_en = be;
      if (cmd == CMD_WR) begin
         w = expect_w(addr, r.data, be);
         for (int k = 0; k < 16; k++) begin
            if (w.strb[k]) ref_mem[line][8*k +: 8] = w.data[8*k +: 8];
         end
      end
      r.exp_data = ref_mem[line];
      if (line == 15) ref_err = 1'b1;
      r.exp_err = ref_err;
      table_rows[n_rows] = r;
      n_rows++;
   endtask

   task automatic send_req(int idx);
      test_row_t r;
      logic accepted;
      int t;
      r = table_rows[idx];
      i_l2_req = row_req(idx);
      i_l2_req_valid = 1'b1;
      t = 0;
      do begin
         accepted = o_l2_req_ready;
         @(posedge i_clk);
         #2;
         t++;
         if (!accepted && t > TIMEOUT) begin
            report_fail($sformatf("request row %0d was never accepted", idx));
         end
      end while (!accepted);
      if (r.cmd == CMD_WR) begin
         exp_aw_q.push_back('{addr: r.addr & ~paddr_t'(LINE_BYTES - 1), id: r.tag});
         exp_w_q.push_back(expect_w(r.addr, r.data, r.byte_en));
         exp_ack_q.push_back(r.tag);
      end else begin
         exp_ar_addr_q.push_back(r.addr);
         exp_ar_id_q.push_back(r.tag);
         exp_resp_q.push_back('{tag: r.tag, data: r.exp_data});
      end
      i_l2_req_valid = 1'b0;
   endtask

   task automatic wait_idle(string name);
      int t;
      t = 0;
      do begin
         @(posedge i_clk);
         #2;
         t++;
         if (t > TIMEOUT) report_fail($sformatf("%s did not complete in time", name));
      end while (pending_count() != 0);
   endtask

   // ------------------------------
   // AXI slave memory model
   // ------------------------------
   initial begin
      r_beat_t r_q [$];
      axi_aw_t aw_q [$];
      axi_w_t  w_q [$];
      tag_t    b_q [$];
      axi_resp_t b_resp_q [$];
      axi_aw_t aw;
      axi_w_t  w;
      logic    hold;
      logic [15:0] rnd;
      int cycle;
      int line;
      cycle = 0;
      for (int i = 0; i < 16; i++) slave_mem[i] = fill_line(i);
      {i_axi_ar_ready, i_axi_aw_ready, i_axi_w_ready} = '0;
      {i_axi_b_valid, i_axi_b_id, i_axi_b_resp} = '0;
      {i_axi_r_valid, i_axi_r_id, i_axi_r_data, i_axi_r_resp} = '0;
      forever begin
         @(posedge i_clk);
         cycle++;
         hold = hold_ready;
         if (o_axi_ar_valid && i_axi_ar_ready) begin
            line = int'(o_axi_ar_addr[7:4]);
            r_q.push_back('{o_axi_ar_id, slave_mem[line],
                            (line == 15) ? RESP_SLVERR : RESP_OKAY, cycle + next_rand() % 4});
         end
         if (o_axi_aw_valid && i_axi_aw_ready) aw_q.push_back(o_axi_aw);
         if (o_axi_w_valid && i_axi_w_ready) w_q.push_back(o_axi_w);
         if (aw_q.size() != 0 && w_q.size() != 0) begin
            aw = aw_q.pop_front();
            w = w_q.pop_front();
            line = int'(aw.addr[7:4]);
            for (int k = 0; k < 16; k++) begin
               if (w.strb[k]) slave_mem[line][8*k +: 8] = w.data[8*k +: 8];
            end
            b_q.push_back(aw.id);
            b_resp_q.push_back((line == 15) ? RESP_SLVERR : RESP_OKAY);
         end
         #2;
         rnd = next_rand();
         i_axi_ar_ready = !hold && rnd[0];
         i_axi_aw_ready = !hold && rnd[1];
         i_axi_w_ready  = !hold && rnd[2];
         i_axi_r_valid = (r_q.size() != 0) && (r_q[0].due <= cycle);
         if (i_axi_r_valid) begin
            {i_axi_r_id, i_axi_r_data, i_axi_r_resp} = {r_q[0].id, r_q[0].data, r_q[0].resp};
            void'(r_q.pop_front());
         end
         i_axi_b_valid = (b_q.size() != 0);
         if (i_axi_b_valid) begin
            i_axi_b_id = b_q.pop_front();
            i_axi_b_resp = b_resp_q.pop_front();
         end
      end
   end

   // ------------------------------
   // response monitor
   // ------------------------------
   initial begin
      forever begin
         @(posedge i_clk);
         if (u_l2_axi_bridge.u_l2_axi_bridge_sva.fail_count != 0) begin
            report_fail("a bound AXI protocol assertion failed");
         end
         if (i_reset_n) begin
            if (o_axi_ar_valid && i_axi_ar_ready) begin
               if (exp_ar_addr_q.size() == 0) report_fail("AR fired with no read pending");
               check_addr("ar addr", exp_ar_addr_q.pop_front(), o_axi_ar_addr);
               check_tag("ar id", exp_ar_id_q.pop_front(), o_axi_ar_id);
            end
            if (o_axi_aw_valid && i_axi_aw_ready) begin
               if (exp_aw_q.size() == 0) report_fail("AW fired with no write pending");
               check_aw("aw fire", exp_aw_q.pop_front(), o_axi_aw);
            end
            if (o_axi_w_valid && i_axi_w_ready) begin
               if (exp_w_q.size() == 0) report_fail("W fired with no write pending");
               check_w("w fire", exp_w_q.pop_front(), o_axi_w);
            end
            if (o_l2_resp_valid) begin
               if (exp_resp_q.size() == 0) report_fail("read response with no read pending");
               check_resp("read response", exp_resp_q.pop_front(), o_l2_resp);
            end
            if (o_wr_ack_valid) begin
               if (exp_ack_q.size() == 0) report_fail("write ack with no write pending");
               check_tag("write ack", exp_ack_q.pop_front(), o_wr_ack_tag);
            end
         end
      end
   end

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      i_reset_n = 1'b0;
      i_l2_req_valid = 1'b0;
      i_l2_req = '0;
      for (int i = 0; i < 16; i++) ref_mem[i] = fill_line(i);
      // writes at offsets 0, 5 and 12 before the read-back and the error line
      add_row(CMD_WR, 32'h010, 6'd1, 16'h00ff);
      add_row(CMD_WR, 32'h025, 6'd2, 16'h0f0f);
      add_row(CMD_WR, 32'h03c, 6'd3, 16'hffff);
      add_row(CMD_RD, 32'h010, 6'd4, 16'h0000);
      add_row(CMD_RD, 32'h020, 6'd5, 16'h0000);
      add_row(CMD_RD, 32'h030, 6'd6, 16'h0000);
      add_row(CMD_WR, 32'h0f4, 6'd7, 16'h0003);
      add_row(CMD_RD, 32'h040, 6'd8, 16'h0000);
      // back-pressure burst opens with a read that blocks the head
      add_row(CMD_RD, 32'h050, 6'd9, 16'h0000);
      add_row(CMD_WR, 32'h058, 6'd10, 16'hff00);
      add_row(CMD_RD, 32'h050, 6'd11, 16'h0000);
      add_row(CMD_WR, 32'h063, 6'd12, 16'h00f0);
      add_row(CMD_WR, 32'h070, 6'd13, 16'h0001);
      add_row(CMD_RD, 32'h060, 6'd14, 16'h0000);
      repeat (5) @(posedge i_clk);
      #2;
      i_reset_n = 1'b1;
      @(posedge i_clk);
      #2;
      check_flag("reset ar_valid", 1'b0, o_axi_ar_valid);
      check_flag("reset aw_valid", 1'b0, o_axi_aw_valid);
      check_flag("reset w_valid", 1'b0, o_axi_w_valid);
      check_flag("reset resp_valid", 1'b0, o_l2_resp_valid);
      check_flag("reset ack_valid", 1'b0, o_wr_ack_valid);
      check_flag("reset bus_error", 1'b0, o_bus_error);
      check_flag("reset req_ready", 1'b1, o_l2_req_ready);
      for (int i = 0; i < 8; i++) begin
         send_req(i);
         wait_idle($sformatf("row %0d", i));
         check_flag($sformatf("row %0d bus_error", i), table_rows[i].exp_err, o_bus_error);
      end
      hold_ready = 1'b1;
      @(posedge i_clk);
      #2;
      for (int i = 8; i < 12; i++) send_req(i);
      check_flag("queue full req_ready", 1'b0, o_l2_req_ready);
      // fifth request stays offered against the full queue
      i_l2_req = row_req(12);
      i_l2_req_valid = 1'b1;
      repeat (4) begin
         @(posedge i_clk);
         #2;
         check_flag("held req_ready", 1'b0, o_l2_req_ready);
      end
      hold_ready = 1'b0;
      for (int i = 12; i < N_ROWS; i++) send_req(i);
      wait_idle("back-pressure burst");
      check_flag("sticky bus_error", table_rows[N_ROWS-1].exp_err, o_bus_error);
      repeat (10) @(posedge i_clk);
      if (u_l2_axi_bridge.u_l2_axi_bridge_sva.fail_count != 0) begin
         report_fail("a bound AXI protocol assertion failed");
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule

//--- tests/l2_axi_bridge_sva.sv
module l2_axi_bridge_sva (
   input logic                    i_clk,
   input logic                    i_reset_n,
   input logic                    i_ar_valid,
   input logic                    i_ar_ready,
   input axi_bridge_pkg::paddr_t  i_ar_addr,
   input axi_bridge_pkg::tag_t    i_ar_id,
   input logic                    i_aw_valid,
   input logic                    i_aw_ready,
   input axi_bridge_pkg::axi_aw_t i_aw,
   input logic                    i_w_valid,
   input logic                    i_w_ready,
   input axi_bridge_pkg::axi_w_t  i_w,
   input logic                    i_resp_valid,
   input logic                    i_ack_valid
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // valid held with a stable payload until ready
   ar_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_ar_valid && !i_ar_ready |=> i_ar_valid && $stable(i_ar_addr) && $stable(i_ar_id))
      else begin
         fail_count++;
         $error("AR valid or payload changed before ready");
      end
   aw_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_aw_valid && !i_aw_ready |=> i_aw_valid && $stable(i_aw))
      else begin
         fail_count++;
         $error("AW valid or payload changed before ready");
      end
   w_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
      i_w_valid && !i_w_ready |=> i_w_valid && $stable(i_w))
      else begin
         fail_count++;
         $error("W valid or payload changed before ready");
      end

   // quiet while in reset
   reset_quiet: assert property (@(posedge i_clk)
      !i_reset_n |-> !(i_ar_valid || i_aw_valid || i_w_valid || i_resp_valid || i_ack_valid))
      else begin
         fail_count++;
         $error("valid or strobe high during reset");
      end

endmodule

bind l2_axi_bridge l2_axi_bridge_sva u_l2_axi_bridge_sva (
   .i_clk        (i_clk),
   .i_reset_n    (i_reset_n),
   .i_ar_valid   (o_axi_ar_valid),
   .i_ar_ready   (i_axi_ar_ready),
   .i_ar_addr    (o_axi_ar_addr),
   .i_ar_id      (o_axi_ar_id),
   .i_aw_valid   (o_axi_aw_valid),
   .i_aw_ready   (i_axi_aw_ready),
   .i_aw         (o_axi_aw),
   .i_w_valid    (o_axi_w_valid),
   .i_w_ready    (i_axi_w_ready),
   .i_w          (o_axi_w),
   .i_resp_valid (o_l2_resp_valid),
   .i_ack_valid  (o_wr_ack_valid)
);

//--- rtl/l2_axi_bridge.sv
module l2_axi_bridge #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                       i_clk,
   input  logic                       i_reset_n,

   // l2 request side
   input  logic                       i_l2_req_valid,
   input  axi_bridge_pkg::l2_req_t    i_l2_req,
   output logic                       o_l2_req_ready,

   // AXI read address
   output logic                       o_axi_ar_valid,
   input  logic                       i_axi_ar_ready,
   output axi_bridge_pkg::paddr_t     o_axi_ar_addr,
   output axi_bridge_pkg::tag_t       o_axi_ar_id,

   // AXI write address and data
   output logic                       o_axi_aw_valid,
   input  logic                       i_axi_aw_ready,
   output axi_bridge_pkg::axi_aw_t    o_axi_aw,
   output logic                       o_axi_w_valid,
   input  logic                       i_axi_w_ready,
   output axi_bridge_pkg::axi_w_t     o_axi_w,

   // AXI responses, always accepted
   input  logic                       i_axi_b_valid,
   input  axi_bridge_pkg::tag_t       i_axi_b_id,
   input  axi_bridge_pkg::axi_resp_t  i_axi_b_resp,
   input  logic                       i_axi_r_valid,
   input  axi_bridge_pkg::tag_t       i_axi_r_id,
   input  axi_bridge_pkg::line_data_t i_axi_r_data,
   input  axi_bridge_pkg::axi_resp_t  i_axi_r_resp,

   // l2 response side
   output logic                       o_l2_resp_valid,
   output axi_bridge_pkg::l2_resp_t   o_l2_resp,
   output logic                       o_wr_ack_valid,
   output axi_bridge_pkg::tag_t       o_wr_ack_tag,
   output logic                       o_bus_error
);
   import axi_bridge_pkg::*;

   l2_req_t w_head;
   l2_req_t w_wr_req;
   logic    w_not_empty;
   logic    w_full;
   logic    w_pop;

   assign o_l2_req_ready = ~w_full;

   // read address straight from the queue head
   assign o_axi_ar_addr = w_head.addr;
   assign o_axi_ar_id   = w_head.tag;

   // ------------------------------
   // request path
   // ------------------------------
   l2_req_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_l2_req_fifo (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_push      (i_l2_req_valid),
      .i_req       (i_l2_req),
      .i_pop       (w_pop),
      .o_head      (w_head),
      .o_not_empty (w_not_empty),
      .o_full      (w_full)
   );

   axi_bridge_ctrl u_axi_bridge_ctrl (
      .i_clk       (i_clk),
      .i_reset_n   (i_reset_n),
      .i_head      (w_head),
      .i_not_empty (w_not_empty),
      .o_pop       (w_pop),
      .o_wr_req    (w_wr_req),
      .o_ar_valid  (o_axi_ar_valid),
      .i_ar_ready  (i_axi_ar_ready),
      .o_aw_valid  (o_axi_aw_valid),
      .i_aw_ready  (i_axi_aw_ready),
      .o_w_valid   (o_axi_w_valid),
      .i_w_ready   (i_axi_w_ready)
   );

   axi_write_align u_axi_write_align (
      .i_req (w_wr_req),
      .o_aw  (o_axi_aw),
      .o_w   (o_axi_w)
   );

   // ------------------------------
   // response path
   // ------------------------------
   axi_resp_collect u_axi_resp_collect (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_r_valid    (i_axi_r_valid),
      .i_r_id       (i_axi_r_id),
      .i_r_data     (i_axi_r_data),
      .i_r_resp     (i_axi_r_resp),
      .i_b_valid    (i_axi_b_valid),
      .i_b_id       (i_axi_b_id),
      .i_b_resp     (i_axi_b_resp),
      .o_resp_valid (o_l2_resp_valid),
      .o_resp       (o_l2_resp),
      .o_ack_valid  (o_wr_ack_valid),
      .o_ack_tag    (o_wr_ack_tag),
      .o_error      (o_bus_error)
   );

endmodule

//--- rtl/axi_resp_collect.sv
module axi_resp_collect (
   input  logic                       i_clk,
   input  logic                       i_reset_n,

   input  logic                       i_r_valid,
   input  axi_bridge_pkg::tag_t       i_r_id,
   input  axi_bridge_pkg::line_data_t i_r_data,
   input  axi_bridge_pkg::axi_resp_t  i_r_resp,

   input  logic                       i_b_valid,
   input  axi_bridge_pkg::tag_t       i_b_id,
   input  axi_bridge_pkg::axi_resp_t  i_b_resp,

   output logic                       o_resp_valid,
   output axi_bridge_pkg::l2_resp_t   o_resp,
   output logic                       o_ack_valid,
   output axi_bridge_pkg::tag_t       o_ack_tag,
   output logic                       o_error
);
   import axi_bridge_pkg::*;

   logic     r_resp_valid;
   l2_resp_t r_resp;
   logic     r_ack_valid;
   tag_t     r_ack_tag;
   logic     r_error;
   logic     w_r_err;
   logic     w_b_err;

   assign w_r_err = i_r_valid & (i_r_resp != RESP_OKAY);
   assign w_b_err = i_b_valid & (i_b_resp != RESP_OKAY);

   // strobes and sticky error
   always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_resp_valid <= 1'b0;
         r_ack_valid  <= 1'b0;
         r_error      <= 1'b0;
      end else begin
         r_resp_valid <= i_r_valid;
         r_ack_valid  <= i_b_valid;
         r_error      <= r_error | w_r_err | w_b_err;
      end
   end

   // beat payloads
   always_ff @(posedge i_clk) begin
      if (i_r_valid) begin
         r_resp.tag  <= i_r_id;
         r_resp.data <= i_r_data;
      end
      if (i_b_valid) begin
         r_ack_tag <= i_b_id;
      end
   end

   assign o_resp_valid = r_resp_valid;
   assign o_resp       = r_resp;
   assign o_ack_valid  = r_ack_valid;
   assign o_ack_tag    = r_ack_tag;
   assign o_error      = r_error;

endmodule

//--- rtl/axi_write_align.sv
module axi_write_align (
   input  axi_bridge_pkg::l2_req_t i_req,
   output axi_bridge_pkg::axi_aw_t o_aw,
   output axi_bridge_pkg::axi_w_t  o_w
);
   import axi_bridge_pkg::*;

   logic [OFS_W-1:0] w_ofs;
   logic [OFS_W+2:0] w_bit_shift;

   // byte offset inside the line
   assign w_ofs       = i_req.addr[OFS_W-1:0];
   assign w_bit_shift = {w_ofs, 3'b000};

   // ------------------------------
   // address channel
   // ------------------------------

   // aligned down to the line
   assign o_aw.addr = {i_req.addr[PADDR_W-1:OFS_W], {OFS_W{1'b0}}};
   assign o_aw.id   = i_req.tag;

   // ------------------------------
   // data channel
   // ------------------------------

   // lanes past the top of the line fall off
   assign o_w.data = i_req.data << w_bit_shift;
   assign o_w.strb = i_req.byte_en << w_ofs;

endmodule

//--- rtl/axi_bridge_ctrl.sv
module axi_bridge_ctrl (
   input  logic                    i_clk,
   input  logic                    i_reset_n,

   input  axi_bridge_pkg::l2_req_t i_head,
   input  logic                    i_not_empty,
   output logic                    o_pop,

   output axi_bridge_pkg::l2_req_t o_wr_req,

   output logic                    o_ar_valid,
   input  logic                    i_ar_ready,

   output logic                    o_aw_valid,
   input  logic                    i_aw_ready,

   output logic                    o_w_valid,
   input  logic                    i_w_ready
);
   import axi_bridge_pkg::*;

   typedef enum logic {
      IDLE    = 1'b0,
      WR_WAIT = 1'b1
   } state_t;

   state_t  r_state;
   l2_req_t r_wr_req;
   logic    r_aw_hold;
   logic    r_w_hold;

   logic    w_idle;
   logic    w_wr_wait;
   logic    w_head_rd;
   logic    w_head_wr;
   logic    w_ar_fire;
   logic    w_aw_fire;
   logic    w_w_fire;
   logic    w_wr_done;

   assign w_idle    = (r_state == IDLE);
   assign w_wr_wait = (r_state == WR_WAIT);

   // head decode, only looked at while idle
   assign w_head_rd = w_idle & i_not_empty & (i_head.cmd == CMD_RD);
   assign w_head_wr = w_idle & i_not_empty & (i_head.cmd == CMD_WR);

   // ------------------------------
   // channel valids
   // ------------------------------
   assign o_ar_valid = w_head_rd;
   assign o_aw_valid = w_wr_wait & ~r_aw_hold;
   assign o_w_valid  = w_wr_wait & ~r_w_hold;

   assign w_ar_fire = o_ar_valid & i_ar_ready;
   assign w_aw_fire = o_aw_valid & i_aw_ready;
   assign w_w_fire  = o_w_valid & i_w_ready;

   assign w_wr_done = r_aw_hold & r_w_hold;

   // reads leave on AR fire, writes as soon as they are latched
   assign o_pop = w_ar_fire | w_head_wr;

   // ------------------------------
   // state machine
   // ------------------------------
   always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_state   <= IDLE;
         r_aw_hold <= 1'b0;
         r_w_hold  <= 1'b0;
      end else begin
         case (r_state)
            IDLE: begin
               if (w_head_wr) begin
                  r_state <= WR_WAIT;
               end
            end
            WR_WAIT: begin
               r_aw_hold <= r_aw_hold | w_aw_fire;
               r_w_hold  <= r_w_hold | w_w_fire;
               // both channels done, back to idle
               if (w_wr_done) begin
                  r_state   <= IDLE;
                  r_aw_hold <= 1'b0;
                  r_w_hold  <= 1'b0;
               end
            end
            default: begin
               r_state <= IDLE;
            end
         endcase
      end
   end

   // write request held for the aligner
   always_ff @(posedge i_clk) begin
      if (w_head_wr) begin
         r_wr_req <= i_head;
      end
   end

   assign o_wr_req = r_wr_req;

endmodule

//--- rtl/l2_req_fifo.sv
module l2_req_fifo #(
   parameter int DEPTH = 4
) (
   input  logic                    i_clk,
   input  logic                    i_reset_n,
   input  logic                    i_push,
   input  axi_bridge_pkg::l2_req_t i_req,
   input  logic                    i_pop,
   output axi_bridge_pkg::l2_req_t o_head,
   output logic                    o_not_empty,
   output logic                    o_full
);
   import axi_bridge_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   l2_req_t          r_mem [DEPTH];
   logic [PTR_W-1:0] r_wr_ptr;
   logic [PTR_W-1:0] r_rd_ptr;
   logic [CNT_W-1:0] r_count;
   logic             w_do_push;
   logic             w_do_pop;

   // overflow push and underflow pop are dropped
   assign w_do_push = i_push & ~o_full;
   assign w_do_pop  = i_pop & o_not_empty;

   always_ff @(posedge i_clk) begin
      if (w_do_push) begin
         r_mem[r_wr_ptr] <= i_req;
      end
   end

   always_ff @(posedge i_clk, negedge i_reset_n) begin
      if (!i_reset_n) begin
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
      end else begin
         if (w_do_push) begin
            r_wr_ptr <= (r_wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_wr_ptr + PTR_W'(1);
         end
         if (w_do_pop) begin
            r_rd_ptr <= (r_rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : r_rd_ptr + PTR_W'(1);
         end
         case ({w_do_push, w_do_pop})
            2'b10:   r_count <= r_count + CNT_W'(1);
            2'b01:   r_count <= r_count - CNT_W'(1);
            default: r_count <= r_count;
         endcase
      end
   end

   // head is the oldest entry
   assign o_head      = r_mem[r_rd_ptr];
   assign o_not_empty = (r_count != '0);
   assign o_full      = (r_count == CNT_W'(DEPTH));

endmodule

//--- rtl/axi_bridge_pkg.sv
package axi_bridge_pkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int PADDR_W    = 32;
   localparam int LINE_W     = 128;
   localparam int LINE_BYTES = LINE_W / 8;
   localparam int OFS_W      = $clog2(LINE_BYTES);
   localparam int TAG_W      = 6;

   // ------------------------------
   // vector types
   // ------------------------------
   typedef logic [PADDR_W-1:0]    paddr_t;
   typedef logic [LINE_W-1:0]     line_data_t;
   typedef logic [LINE_BYTES-1:0] line_strb_t;
   typedef logic [TAG_W-1:0]      tag_t;

   // l2 command code
   typedef logic [0:0] l2_cmd_t;

   localparam l2_cmd_t CMD_RD = 1'b0;
   localparam l2_cmd_t CMD_WR = 1'b1;

   // AXI response code
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t RESP_OKAY   = 2'b00;
   localparam axi_resp_t RESP_SLVERR = 2'b10;

   // ------------------------------
   // structs
   // ------------------------------

   // data and byte_en right-justified, lane 0 is the byte at addr
   typedef struct packed {
      l2_cmd_t    cmd;
      paddr_t     addr;
      tag_t       tag;
      line_data_t data;
      line_strb_t byte_en;
   } l2_req_t;

   typedef struct packed {
      tag_t       tag;
      line_data_t data;
   } l2_resp_t;

   typedef struct packed {
      paddr_t addr;
      tag_t   id;
   } axi_aw_t;

   typedef struct packed {
      line_data_t data;
      line_strb_t strb;
   } axi_w_t;

endpackage
